// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // ----------------------------------------
    // Cache geometry
    // ----------------------------------------

    localparam int WORD_BITS   = 32;
    localparam int BYTE_BITS   = 2;
    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = WORD_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    localparam int LINE_WORDS  = 1 << OFFSET_BITS;
    localparam int NUM_LINES   = 1 << INDEX_BITS;
    localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;

    // ----------------------------------------
    // Memory burst and statistics
    // ----------------------------------------

    // Length field carries beats minus one
    localparam int LEN_BITS = 8;
    localparam logic [LEN_BITS-1:0] BURST_LEN = LEN_BITS'(LINE_WORDS - 1);

    localparam int STAT_BITS = 32;

    // ----------------------------------------
    // Fetch controller state codes
    // ----------------------------------------

    localparam int STATE_BITS = 2;
    localparam logic [STATE_BITS-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_BITS-1:0] ST_LOOKUP = 2'd1;
    localparam logic [STATE_BITS-1:0] ST_REFILL = 2'd2;
    localparam logic [STATE_BITS-1:0] ST_ACK    = 2'd3;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    // Fetch address, raw word or split into cache fields
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] word;
            logic [BYTE_BITS-1:0]   byte_sel;
        } fields;
    } fetch_addr_t;

    // Event counter width
    typedef logic [STAT_BITS-1:0] stat_count_t;

endpackage

`default_nettype wire

// ==== flist.f ====
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
hdl/cache_stats.sv
hdl/icache_top.sv
tb/icache_props.sv
tb/icache_tb.sv

// ==== hdl/cache_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_stats (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     hit_event,
    input  wire                     miss_event,
    output icache_pkg::stat_count_t hit_count,
    output icache_pkg::stat_count_t miss_count
);

    // Stops at all ones instead of wrapping
    function automatic icache_pkg::stat_count_t sat_inc(input icache_pkg::stat_count_t count);
        return (&count) ? count : count + 1'b1;
    endfunction

    // ----------------------------------------
    // Event counters
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit_event) begin
                hit_count <= sat_inc(hit_count);
            end
            if (miss_event) begin
                miss_count <= sat_inc(miss_count);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 fetch_req,
    input  wire icache_pkg::fetch_addr_t        fetch_addr,
    output logic                                fetch_ack,
    output logic [icache_pkg::WORD_BITS-1:0]    fetch_data,
    output logic                                mem_start,
    output logic [icache_pkg::WORD_BITS-1:0]    mem_addr,
    output logic [icache_pkg::LEN_BITS-1:0]     mem_len,
    input  wire                                 mem_valid,
    input  wire [icache_pkg::WORD_BITS-1:0]     mem_rdata,
    output icache_pkg::stat_count_t             hit_count,
    output icache_pkg::stat_count_t             miss_count
);

    icache_pkg::fetch_addr_t            lookup_addr;
    logic                               hit;
    logic [icache_pkg::WORD_BITS-1:0]   rd_word;
    logic                               refill_go;
    logic                               refill_done;
    logic                               fill_valid;
    logic [icache_pkg::WORD_BITS-1:0]   fill_word;
    logic                               hit_event;
    logic                               miss_event;

    // ----------------------------------------
    // Fetch side
    // ----------------------------------------

    icache_ctrl i_ctrl (
        .clock       (clock),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_data  (fetch_data),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .rd_word     (rd_word),
        .refill_go   (refill_go),
        .refill_done (refill_done),
        .hit_event   (hit_event),
        .miss_event  (miss_event)
    );

    icache_tag_array i_tags (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .refill_done (refill_done),
        .hit         (hit)
    );

    icache_data_array i_data (
        .clock       (clock),
        .lookup_addr (lookup_addr),
        .fill_valid  (fill_valid),
        .fill_word   (fill_word),
        .rd_word     (rd_word)
    );

    // ----------------------------------------
    // Memory side and statistics
    // ----------------------------------------

    icache_refill i_refill (
        .clock       (clock),
        .reset       (reset),
        .refill_go   (refill_go),
        .lookup_addr (lookup_addr),
        .mem_start   (mem_start),
        .mem_addr    (mem_addr),
        .mem_len     (mem_len),
        .mem_valid   (mem_valid),
        .mem_rdata   (mem_rdata),
        .fill_valid  (fill_valid),
        .fill_word   (fill_word),
        .refill_done (refill_done)
    );

    cache_stats i_stats (
        .clock       (clock),
        .reset       (reset),
        .hit_event   (hit_event),
        .miss_event  (miss_event),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 fetch_req,
    input  wire icache_pkg::fetch_addr_t        fetch_addr,
    output logic                                fetch_ack,
    output logic [icache_pkg::WORD_BITS-1:0]    fetch_data,
    output icache_pkg::fetch_addr_t             lookup_addr,
    input  wire                                 hit,
    input  wire [icache_pkg::WORD_BITS-1:0]     rd_word,
    output logic                                refill_go,
    input  wire                                 refill_done,
    output logic                                hit_event,
    output logic                                miss_event
);

    logic [icache_pkg::STATE_BITS-1:0] state;

    // Set once the current request has missed
    logic missed;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= icache_pkg::ST_IDLE;
            fetch_ack  <= 1'b0;
            refill_go  <= 1'b0;
            hit_event  <= 1'b0;
            miss_event <= 1'b0;
            missed     <= 1'b0;
        end else begin
            refill_go  <= 1'b0;
            hit_event  <= 1'b0;
            miss_event <= 1'b0;
            case (state)
                icache_pkg::ST_IDLE: begin
                    if (fetch_req) begin
                        missed <= 1'b0;
                        state  <= icache_pkg::ST_LOOKUP;
                    end
                end
                icache_pkg::ST_LOOKUP: begin
                    if (hit) begin
                        // Post-refill hit was already counted as a miss
                        fetch_ack <= 1'b1;
                        hit_event <= !missed;
                        state     <= icache_pkg::ST_ACK;
                    end else begin
                        refill_go  <= 1'b1;
                        miss_event <= !missed;
                        missed     <= 1'b1;
                        state      <= icache_pkg::ST_REFILL;
                    end
                end
                icache_pkg::ST_REFILL: begin
                    // Reread the new line through the normal path
                    if (refill_done) begin
                        state <= icache_pkg::ST_LOOKUP;
                    end
                end
                icache_pkg::ST_ACK: begin
                    if (!fetch_req) begin
                        fetch_ack <= 1'b0;
                        state     <= icache_pkg::ST_IDLE;
                    end
                end
                default: state <= icache_pkg::ST_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Address and data capture
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (state == icache_pkg::ST_IDLE && fetch_req) begin
            lookup_addr.raw <= fetch_addr.raw;
        end
        if (state == icache_pkg::ST_LOOKUP && hit) begin
            fetch_data <= rd_word;  // held through ACK
        end
    end

endmodule

`default_nettype wire

// ==== icache/icache_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
    input  wire                                 clock,
    input  wire icache_pkg::fetch_addr_t        lookup_addr,
    input  wire                                 fill_valid,
    input  wire [icache_pkg::WORD_BITS-1:0]     fill_word,
    output logic [icache_pkg::WORD_BITS-1:0]    rd_word
);

    // ----------------------------------------
    // Line storage
    // ----------------------------------------

    logic [icache_pkg::LINE_BITS-1:0]  lines [icache_pkg::NUM_LINES];
    logic [icache_pkg::LINE_BITS-1:0]  line;
    logic [icache_pkg::INDEX_BITS-1:0] index;

    assign index = lookup_addr.fields.index;
    assign line  = lines[index];

    // Beats enter at the top and move down
    // After four beats word 0 sits in the low bits
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            lines[index] <= {fill_word, line[icache_pkg::LINE_BITS-1:icache_pkg::WORD_BITS]};
        end
    end

    // ----------------------------------------
    // Word select
    // ----------------------------------------

    always_comb begin
        rd_word = line[lookup_addr.fields.word * icache_pkg::WORD_BITS +: icache_pkg::WORD_BITS];
    end

endmodule

`default_nettype wire

// ==== icache/icache_refill.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 refill_go,
    input  wire icache_pkg::fetch_addr_t        lookup_addr,
    output logic                                mem_start,
    output logic [icache_pkg::WORD_BITS-1:0]    mem_addr,
    output logic [icache_pkg::LEN_BITS-1:0]     mem_len,
    input  wire                                 mem_valid,
    input  wire [icache_pkg::WORD_BITS-1:0]     mem_rdata,
    output logic                                fill_valid,
    output logic [icache_pkg::WORD_BITS-1:0]    fill_word,
    output logic                                refill_done
);

    logic                               busy;
    logic                               launch;
    logic                               last_beat;
    logic [icache_pkg::OFFSET_BITS-1:0] beat_cnt;

    // ----------------------------------------
    // Burst control
    // ----------------------------------------

    assign launch = refill_go && !busy;

    // Counter reaches all ones on the final beat of a line
    assign last_beat = mem_valid && (&beat_cnt);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy        <= 1'b0;
            mem_start   <= 1'b0;
            refill_done <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            mem_start   <= launch;
            refill_done <= busy && last_beat;
            if (launch) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (busy && mem_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Line aligned, held until the burst is over
    always_ff @(posedge clock) begin
        if (launch) begin
            mem_addr <= {lookup_addr.fields.tag,
                         lookup_addr.fields.index,
                         {(icache_pkg::OFFSET_BITS + icache_pkg::BYTE_BITS){1'b0}}};
        end
    end

    assign mem_len = icache_pkg::BURST_LEN;

    // ----------------------------------------
    // Beat forwarding
    // ----------------------------------------

    // Every beat is taken, no back-pressure to memory
    assign fill_valid = busy && mem_valid;
    assign fill_word  = mem_rdata;

endmodule

`default_nettype wire

// ==== icache/icache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
    input  wire                         clock,
    input  wire                         reset,
    input  wire icache_pkg::fetch_addr_t lookup_addr,
    input  wire                         refill_done,
    output logic                        hit
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    logic [icache_pkg::TAG_BITS-1:0]   tags [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0]  valid;

    logic [icache_pkg::INDEX_BITS-1:0] index;
    logic [icache_pkg::TAG_BITS-1:0]   tag;

    assign index = lookup_addr.fields.index;
    assign tag   = lookup_addr.fields.tag;

    // ----------------------------------------
    // Update at end of refill
    // ----------------------------------------

    // Only reset clears lines, no invalidate path
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (refill_done) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (refill_done) begin
            tags[index] <= tag;
        end
    end

    // ----------------------------------------
    // Lookup
    // ----------------------------------------

    // Stored tag must match and the line must be valid
    assign hit = valid[index] && (tags[index] == tag);

endmodule

`default_nettype wire

// ==== tb/icache_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_props (
    input wire        clock,
    input wire        reset,
    input wire        fetch_req,
    input wire        fetch_ack,
    input wire        mem_start,
    input wire [31:0] mem_addr,
    input wire        mem_valid
);

    logic       pending;
    logic [1:0] beats;

    // Number of failed properties
    int assert_errors = 0;

    // Tracks the burst in flight, four beats per line
    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
            beats   <= '0;
        end else if (mem_start) begin
            pending <= 1'b1;
            beats   <= '0;
        end else if (pending && mem_valid) begin
            beats <= beats + 1'b1;
            if (&beats) begin
                pending <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Handshake properties
    // ----------------------------------------

    ack_release: assert property (@(posedge clock) disable iff (reset)
        $fell(fetch_ack) |-> !$past(fetch_req))
        else begin
            assert_errors++;
            $error("fetch_ack fell while fetch_req was high");
        end

    line_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_start |-> (mem_addr[icache_pkg::OFFSET_BITS + icache_pkg::BYTE_BITS - 1:0] == '0))
        else begin
            assert_errors++;
            $error("mem_addr not line aligned at mem_start");
        end

    single_burst: assert property (@(posedge clock) disable iff (reset)
        mem_start |-> !pending)
        else begin
            assert_errors++;
            $error("mem_start while a burst is outstanding");
        end

endmodule

bind icache_top icache_props i_props (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_ack (fetch_ack),
    .mem_start (mem_start),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid)
);

`default_nettype wire

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    localparam int NUM_FETCHES = 120;
    localparam int WATCHDOG_CYCLES = (NUM_FETCHES + 1) * 40 + 200;

    logic clock;
    logic reset;
    logic fetch_req;
    icache_pkg::fetch_addr_t fetch_addr;
    logic fetch_ack;
    logic [31:0] fetch_data;
    logic mem_start;
    logic [31:0] mem_addr;
    logic [7:0] mem_len;
    logic mem_valid;
    logic [31:0] mem_rdata;
    icache_pkg::stat_count_t hit_count;
    icache_pkg::stat_count_t miss_count;

    // Reference cache state
    logic [icache_pkg::TAG_BITS-1:0] ref_tag [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0] ref_valid;
    icache_pkg::stat_count_t exp_hits;
    icache_pkg::stat_count_t exp_misses;

    // Filled in by the memory model at each burst start
    int start_count;
    icache_pkg::fetch_addr_t last_start_addr;
    logic [7:0] last_start_len;

    int word_errors;
    int addr_errors;
    int count_errors;
    int other_errors;

    icache_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .mem_start  (mem_start),
        .mem_addr   (mem_addr),
        .mem_len    (mem_len),
        .mem_valid  (mem_valid),
        .mem_rdata  (mem_rdata),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ----------------------------------------
    // Memory contents and address pool
    // ----------------------------------------

    // Word at a: a XOR pattern, rotated left by the word field
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] x;
        int unsigned s;
        x = a ^ 32'h5A5A_0F0F;
        s = a[3:2];
        return (x << s) | (x >> (32 - s));
    endfunction

    // Three tags over four indexes, so hits and evictions both happen
    function automatic icache_pkg::fetch_addr_t pick_addr();
        icache_pkg::fetch_addr_t a;
        a.fields.tag      = 24'hC0_0000 | 24'($urandom_range(0, 2));
        a.fields.index    = 4'($urandom_range(0, 3) * 5);
        a.fields.word     = 2'($urandom_range(0, 3));
        a.fields.byte_sel = 2'($urandom_range(0, 3));
        return a;
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            word_errors++;
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::fetch_addr_t exp,
                              input icache_pkg::fetch_addr_t act);
        if (act.raw !== exp.raw) begin
            $display("** Error %s: expected %h, actual %h", name, exp.raw, act.raw);
            addr_errors++;
        end
    endtask

    task automatic check_count(input string name, input icache_pkg::stat_count_t exp,
                               input icache_pkg::stat_count_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            count_errors++;
        end
    endtask

    // ----------------------------------------
    // Fetch driver
    // ----------------------------------------

    // Entered and left 2 ns after a rising edge
    task automatic do_fetch(input int n, input icache_pkg::fetch_addr_t addr);
        string name;
        logic exp_hit;
        logic [31:0] exp_data;
        icache_pkg::fetch_addr_t line;
        int cycles;
        int starts_before;
        name = $sformatf("fetch %0d", n);
        exp_data = mem_word({addr.raw[31:2], 2'b00});
        line.raw = {addr.raw[31:4], 4'h0};
        exp_hit = ref_valid[addr.fields.index] && (ref_tag[addr.fields.index] == addr.fields.tag);
        if (exp_hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
            ref_valid[addr.fields.index] = 1'b1;
            ref_tag[addr.fields.index] = addr.fields.tag;
        end
        starts_before = start_count;
        repeat ($urandom_range(0, 3)) begin
            @(posedge clock);
            #2;
        end
        fetch_req = 1'b1;
        fetch_addr = addr;
        cycles = 0;
        while (!fetch_ack) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        check_word({name, " data"}, exp_data, fetch_data);
        if (exp_hit && cycles != 2) begin
            $display("** Error %s hit latency: expected 2 cycles, actual %0d", name, cycles);
            other_errors++;
        end
        // Slow requester keeps the cache in its ACK state
        repeat ($urandom_range(0, 8)) begin
            @(posedge clock);
            #1;
            if (!fetch_ack) begin
                $display("%s: fetch_ack dropped while fetch_req was still high", name);
                other_errors++;
            end
        end
        check_word({name, " held data"}, exp_data, fetch_data);
        @(posedge clock);
        #2;
        fetch_req = 1'b0;
        fetch_addr.raw = $urandom;
        @(posedge clock);
        #1;
        if (fetch_ack) begin
            $display("%s: fetch_ack still high one cycle after fetch_req dropped", name);
            other_errors++;
        end
        if (start_count - starts_before != (exp_hit ? 0 : 1)) begin
            $display("%s: %0d memory bursts seen for a %s", name, start_count - starts_before,
                     exp_hit ? "hit" : "miss");
            other_errors++;
        end
        if (!exp_hit) begin
            check_addr({name, " burst address"}, line, last_start_addr);
            check_word({name, " burst length"}, 32'(icache_pkg::LINE_WORDS - 1),
                       32'(last_start_len));
        end
        @(posedge clock);
        #2;
        check_count({name, " hit count"}, exp_hits, hit_count);
        check_count({name, " miss count"}, exp_misses, miss_count);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        ref_valid = '0;
        exp_hits = '0;
        exp_misses = '0;
    endtask

    // ----------------------------------------
    // Burst memory model
    // ----------------------------------------

    initial begin : memory_model
        logic [31:0] base;
        mem_valid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clock);
            #1;
            if (mem_start) begin
                start_count++;
                last_start_addr.raw = mem_addr;
                last_start_len = mem_len;
                base = mem_addr;
                @(posedge clock);
                #2;
                for (int b = 0; b < icache_pkg::LINE_WORDS; b++) begin
                    mem_valid = 1'b0;
                    repeat ($urandom_range(0, 2)) begin
                        @(posedge clock);
                        #2;
                    end
                    mem_valid = 1'b1;
                    mem_rdata = mem_word(base + 32'(4 * b));
                    @(posedge clock);
                    #2;
                end
                mem_valid = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin : main
        icache_pkg::fetch_addr_t addr;
        int seed;
        seed = $urandom(76);
        fetch_req = 1'b0;
        fetch_addr = '0;
        start_count = 0;
        word_errors = 0;
        addr_errors = 0;
        count_errors = 0;
        other_errors = 0;
        apply_reset();
        addr = pick_addr();
        for (int n = 0; n < NUM_FETCHES; n++) begin
            if (n == NUM_FETCHES / 2) begin
                // Cached line must miss again after reset
                apply_reset();
                check_count("counts after reset hits", '0, hit_count);
                check_count("counts after reset misses", '0, miss_count);
                do_fetch(n, addr);
            end
            addr = pick_addr();
            do_fetch(n, addr);
        end
        $display("Error counts: word %0d, address %0d, counter %0d, protocol %0d, assertion %0d",
                 word_errors, addr_errors, count_errors, other_errors,
                 i_dut.i_props.assert_errors);
        if (word_errors + addr_errors + count_errors + other_errors
            + i_dut.i_props.assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: fetch handshake did not complete");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
